/* common/network_node_defs.svh */
`ifndef NETWORK_NODE_DEFS_SVH
`define NETWORK_NODE_DEFS_SVH

// Datapath widths
`define NN_PDET_W       5
`define NN_RO_W         5
`define NN_WEIGHT_W     4
`define NN_ACC_W        8
`define NN_INTEG_W      16

// PI gains are unsigned fixed point
`define NN_KP_W         6
`define NN_KP_FRAC      5
`define NN_KI_W         8
`define NN_KI_FRAC      7
`define NN_KP_DEFAULT   9       // 9/32
`define NN_KI_DEFAULT   1       // 1/128

// Oscillator centre frequency in accumulator steps per fpga cycle
`define NN_BIAS         15

// Scales the weighted error sum back towards the detector range
`define NN_COMB_SHIFT   2

`endif

/* common/network_node_pkg.sv */
`include "network_node_defs.svh"

package network_node_pkg;

    typedef logic signed [`NN_PDET_W-1:0] phase_err_t;   // Signed count of fpga cycles
    typedef logic signed [`NN_RO_W-1:0]   ctrl_code_t;
    typedef logic        [`NN_RO_W:0]     freq_word_t;   // One bit wider than the code
    typedef logic        [`NN_WEIGHT_W-1:0] weight_t;

    typedef logic [`NN_KP_W-1:0] kp_t;
    typedef logic [`NN_KI_W-1:0] ki_t;

    // Which edge of the pair arrived first
    typedef enum logic [1:0] {
        IDLE,
        REF_FIRST,
        GEN_FIRST
    } pd_state_e;

    // Four-phase gain load
    typedef enum logic {
        WAIT_REQ,
        HOLD_ACK
    } gain_state_e;

endpackage

/* phase_detector/phase_detector.sv */
`include "network_node_defs.svh"

module phase_detector (
    input  logic                         fpga_clk_i,
    input  logic                         rst_i,
    input  logic                         reference_i,
    input  logic                         generated_i,
    output network_node_pkg::phase_err_t pd_error_o
);
    import network_node_pkg::*;

    localparam int CNT_W   = `NN_PDET_W;
    localparam int CNT_SAT = 2 ** (`NN_PDET_W - 1);   // Magnitude of the most negative error
    localparam int POS_MAX = CNT_SAT - 1;

    pd_state_e        state_q;
    logic             ref_q;
    logic             gen_q;
    logic             ref_rise;
    logic             gen_rise;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_inc;
    phase_err_t       pos_err;
    phase_err_t       neg_err;
    phase_err_t       err_q;

    assign ref_rise = reference_i & ~ref_q;
    assign gen_rise = generated_i & ~gen_q;

    assign cnt_inc = (cnt_q == CNT_W'(CNT_SAT)) ? cnt_q : cnt_q + 1'b1;

    // Generated edge first gives a positive error
    assign pos_err = (cnt_q > CNT_W'(POS_MAX)) ? phase_err_t'(POS_MAX) : phase_err_t'(cnt_q);
    assign neg_err = phase_err_t'(-cnt_q);

    assign pd_error_o = err_q;

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            ref_q   <= 1'b0;
            gen_q   <= 1'b0;
            cnt_q   <= '0;
            err_q   <= '0;
        end else begin
            ref_q <= reference_i;
            gen_q <= generated_i;
            case (state_q)
                IDLE: begin
                    if (ref_rise && gen_rise) begin
                        err_q <= '0;                // Edges coincide
                    end else if (ref_rise) begin
                        state_q <= REF_FIRST;
                        cnt_q   <= CNT_W'(1);
                    end else if (gen_rise) begin
                        state_q <= GEN_FIRST;
                        cnt_q   <= CNT_W'(1);
                    end
                end
                REF_FIRST: begin
                    if (gen_rise) begin
                        err_q   <= neg_err;
                        state_q <= IDLE;
                    end else begin
                        cnt_q <= cnt_inc;
                    end
                end
                GEN_FIRST: begin
                    if (ref_rise) begin
                        err_q   <= pos_err;
                        state_q <= IDLE;
                    end else begin
                        cnt_q <= cnt_inc;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/error_combiner.sv */
`include "network_node_defs.svh"

module error_combiner (
    input  network_node_pkg::weight_t    weight_0_i,
    input  network_node_pkg::weight_t    weight_1_i,
    input  network_node_pkg::weight_t    weight_2_i,
    input  network_node_pkg::weight_t    weight_3_i,
    input  network_node_pkg::phase_err_t error_0_i,
    input  network_node_pkg::phase_err_t error_1_i,
    input  network_node_pkg::phase_err_t error_2_i,
    input  network_node_pkg::phase_err_t error_3_i,
    output network_node_pkg::phase_err_t error_comb_o
);
    import network_node_pkg::*;

    localparam int PROD_W  = `NN_WEIGHT_W + 1 + `NN_PDET_W;
    localparam int SUM_W   = PROD_W + 2;                    // Room for four products
    localparam int ERR_MAX = 2 ** (`NN_PDET_W - 1) - 1;
    localparam int ERR_MIN = -(2 ** (`NN_PDET_W - 1));

    weight_t                  weight [4];
    phase_err_t               error  [4];
    logic signed [PROD_W-1:0] prod   [4];
    logic signed [SUM_W-1:0]  sum;
    logic signed [SUM_W-1:0]  shifted;

    assign weight[0] = weight_0_i;
    assign weight[1] = weight_1_i;
    assign weight[2] = weight_2_i;
    assign weight[3] = weight_3_i;
    assign error[0]  = error_0_i;
    assign error[1]  = error_1_i;
    assign error[2]  = error_2_i;
    assign error[3]  = error_3_i;

    always_comb begin
        sum = '0;
        for (int i = 0; i < 4; i++) begin
            prod[i] = $signed({1'b0, weight[i]}) * error[i];   // Weight is unsigned
            sum     = sum + SUM_W'(prod[i]);
        end
        shifted = sum >>> `NN_COMB_SHIFT;

        if (shifted > ERR_MAX) begin
            error_comb_o = phase_err_t'(ERR_MAX);
        end else if (shifted < ERR_MIN) begin
            error_comb_o = phase_err_t'(ERR_MIN);
        end else begin
            error_comb_o = phase_err_t'(shifted);
        end
    end

endmodule

/* loop_filter/loop_filter.sv */
`include "network_node_defs.svh"

module loop_filter (
    input  logic                         fpga_clk_i,
    input  logic                         rst_i,
    input  logic                         update_i,
    input  network_node_pkg::phase_err_t error_i,
    input  logic                         gain_req_i,
    input  network_node_pkg::kp_t        kp_i,
    input  network_node_pkg::ki_t        ki_i,
    output logic                         gain_ack_o,
    output network_node_pkg::ctrl_code_t dco_cc_o
);
    import network_node_pkg::*;

    localparam int P_W       = `NN_KP_W + 1 + `NN_PDET_W;
    localparam int I_W       = `NN_KI_W + 1 + `NN_PDET_W;
    localparam int INTEG_W   = `NN_INTEG_W;
    localparam int SUM_W     = INTEG_W + 1;
    localparam int INTEG_MAX = 2 ** (INTEG_W - 1) - 1;
    localparam int INTEG_MIN = -(2 ** (INTEG_W - 1));
    localparam int CC_MAX    = 2 ** (`NN_RO_W - 1) - 1;
    localparam int CC_MIN    = -(2 ** (`NN_RO_W - 1));

    gain_state_e               gain_state_q;
    kp_t                       kp_q;
    ki_t                       ki_q;
    logic signed [I_W-1:0]     i_prod;
    logic signed [INTEG_W:0]   integ_sum;
    logic signed [INTEG_W-1:0] integ_next;
    logic signed [INTEG_W-1:0] integ_q;
    logic signed [P_W-1:0]     p_prod;
    logic signed [SUM_W-1:0]   pi_sum;
    ctrl_code_t                cc_next;
    ctrl_code_t                cc_q;

    always_comb begin
        i_prod    = $signed({1'b0, ki_q}) * error_i;
        integ_sum = (INTEG_W + 1)'(integ_q) + (INTEG_W + 1)'(i_prod);
        if (integ_sum > INTEG_MAX) begin
            integ_next = INTEG_W'(INTEG_MAX);
        end else if (integ_sum < INTEG_MIN) begin
            integ_next = INTEG_W'(INTEG_MIN);
        end else begin
            integ_next = integ_sum[INTEG_W-1:0];
        end

        // Proportional term plus the freshly updated integrator
        p_prod = $signed({1'b0, kp_q}) * error_i;
        pi_sum = SUM_W'(p_prod >>> `NN_KP_FRAC) + SUM_W'(integ_next >>> `NN_KI_FRAC);
        if (pi_sum > CC_MAX) begin
            cc_next = ctrl_code_t'(CC_MAX);
        end else if (pi_sum < CC_MIN) begin
            cc_next = ctrl_code_t'(CC_MIN);
        end else begin
            cc_next = ctrl_code_t'(pi_sum);
        end
    end

    assign dco_cc_o = cc_q;

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            gain_state_q <= WAIT_REQ;
            gain_ack_o   <= 1'b0;
            kp_q         <= kp_t'(`NN_KP_DEFAULT);
            ki_q         <= ki_t'(`NN_KI_DEFAULT);
            integ_q      <= '0;
            cc_q         <= '0;
        end else begin
            case (gain_state_q)
                WAIT_REQ: begin
                    if (gain_req_i) begin
                        kp_q         <= kp_i;       // Held stable by the requester
                        ki_q         <= ki_i;
                        gain_ack_o   <= 1'b1;
                        gain_state_q <= HOLD_ACK;
                    end
                end
                HOLD_ACK: begin
                    if (!gain_req_i) begin
                        gain_ack_o   <= 1'b0;
                        gain_state_q <= WAIT_REQ;
                    end
                end
                default: gain_state_q <= WAIT_REQ;
            endcase

            if (update_i) begin
                integ_q <= integ_next;
                cc_q    <= cc_next;
            end
        end
    end

endmodule

/* verilog/dco.sv */
`include "network_node_defs.svh"

module dco (
    input  logic                         fpga_clk_i,
    input  logic                         rst_i,
    input  logic                         enable_i,
    input  network_node_pkg::ctrl_code_t dco_cc_i,
    output logic                         gen_clk_o,
    output logic                         gen_div8_o,
    output logic                         div_tick_o
);
    import network_node_pkg::*;

    localparam int DIFF_W   = `NN_RO_W + 3;
    localparam int FREQ_MAX = 2 ** (`NN_RO_W + 1) - 1;
    localparam int MSB      = `NN_ACC_W - 1;

    logic signed [DIFF_W-1:0] freq_diff;
    freq_word_t               freq_clamp;
    freq_word_t               freq_q;
    logic [`NN_ACC_W-1:0]     acc_q;
    logic [`NN_ACC_W-1:0]     acc_next;
    logic                     gen_rise;
    logic [1:0]               edge_cnt_q;
    logic                     div8_q;
    logic                     tick_q;

    // Higher code means a slower clock
    assign freq_diff = DIFF_W'(`NN_BIAS) - DIFF_W'(dco_cc_i);

    always_comb begin
        if (freq_diff < 0) begin
            freq_clamp = '0;
        end else if (freq_diff > FREQ_MAX) begin
            freq_clamp = freq_word_t'(FREQ_MAX);
        end else begin
            freq_clamp = freq_word_t'(freq_diff);
        end
    end

    assign acc_next = acc_q + `NN_ACC_W'(freq_q);
    assign gen_rise = acc_next[MSB] & ~acc_q[MSB];   // MSB about to go high

    assign gen_clk_o  = acc_q[MSB];
    assign gen_div8_o = div8_q;
    assign div_tick_o = tick_q;

    always_ff @(posedge fpga_clk_i) begin
        if (rst_i) begin
            freq_q     <= freq_word_t'(`NN_BIAS);
            acc_q      <= '0;
            edge_cnt_q <= '0;
            div8_q     <= 1'b0;
            tick_q     <= 1'b0;
        end else begin
            freq_q <= freq_clamp;
            tick_q <= 1'b0;
            if (enable_i) begin
                acc_q <= acc_next;
                if (gen_rise) begin
                    edge_cnt_q <= edge_cnt_q + 1'b1;
                    if (edge_cnt_q == 2'd3) begin
                        div8_q <= ~div8_q;
                        tick_q <= ~div8_q;  // Only on the divided rising edge
                    end
                end
            end
        end
    end

endmodule

/* verilog/network_node.sv */
module network_node (
    input  logic                         fpga_clk_i,
    input  logic                         rst_i,
    input  logic                         enable_i,
    input  logic                         ref_left_i,
    input  logic                         ref_above_i,
    input  logic                         gain_req_i,
    input  network_node_pkg::phase_err_t error_right_i,
    input  network_node_pkg::phase_err_t error_bottom_i,
    input  network_node_pkg::weight_t    weight_left_i,
    input  network_node_pkg::weight_t    weight_above_i,
    input  network_node_pkg::weight_t    weight_right_i,
    input  network_node_pkg::weight_t    weight_below_i,
    input  network_node_pkg::kp_t        kp_i,
    input  network_node_pkg::ki_t        ki_i,
    output logic                         gain_ack_o,
    output logic                         gen_clk_o,
    output logic                         gen_div8_o,
    output network_node_pkg::phase_err_t error_left_o,
    output network_node_pkg::phase_err_t error_above_o,
    output network_node_pkg::ctrl_code_t dco_cc_o
);
    import network_node_pkg::*;

    phase_err_t error_comb;
    logic       div_tick;

    phase_detector pdet_left (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_left_i),
        .generated_i (gen_div8_o),
        .pd_error_o  (error_left_o)
    );

    phase_detector pdet_above (
        .fpga_clk_i  (fpga_clk_i),
        .rst_i       (rst_i),
        .reference_i (ref_above_i),
        .generated_i (gen_div8_o),
        .pd_error_o  (error_above_o)
    );

    // Own detectors first, then the errors reported by the neighbours
    error_combiner u_error_combiner (
        .weight_0_i   (weight_above_i),
        .weight_1_i   (weight_left_i),
        .weight_2_i   (weight_right_i),
        .weight_3_i   (weight_below_i),
        .error_0_i    (error_above_o),
        .error_1_i    (error_left_o),
        .error_2_i    (error_right_i),
        .error_3_i    (error_bottom_i),
        .error_comb_o (error_comb)
    );

    loop_filter u_loop_filter (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .update_i   (div_tick),
        .error_i    (error_comb),
        .gain_req_i (gain_req_i),
        .kp_i       (kp_i),
        .ki_i       (ki_i),
        .gain_ack_o (gain_ack_o),
        .dco_cc_o   (dco_cc_o)
    );

    dco u_dco (
        .fpga_clk_i (fpga_clk_i),
        .rst_i      (rst_i),
        .enable_i   (enable_i),
        .dco_cc_i   (dco_cc_o),
        .gen_clk_o  (gen_clk_o),
        .gen_div8_o (gen_div8_o),
        .div_tick_o (div_tick)
    );

endmodule

/* bench/network_node_tb.sv */
`include "network_node_defs.svh"

module network_node_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import network_node_pkg::*;

    logic fpga_clk, rst, enable, ref_left, ref_above, gain_req, gain_ack;
    logic gen_clk, gen_div8;
    phase_err_t error_right, error_bottom, error_left, error_above;
    weight_t w_left, w_above, w_right, w_below;
    kp_t kp;
    ki_t ki;
    ctrl_code_t dco_cc;

    int cyc = 0, gen_seen_cyc = 0, ref_seen_cyc = 0;
    logic div8_prev = 1'b0, ref_prev = 1'b0;
    int exp_integ, exp_cc, model_kp, model_ki, pd_exp;
    logic model_hold;
    logic chk_reset = 0, chk_open = 0, chk_frozen = 0, chk_model = 0;
    logic chk_hs = 0, chk_sat = 0, pd_chk = 0;
    int err_cnt = 0, err_at_start = 0, pass_cnt = 0, fail_cnt = 0;
    string test_name;
    logic [31:0] rng_state = 32'd1860;

    network_node dut0 (
        .fpga_clk_i(fpga_clk), .rst_i(rst), .enable_i(enable),
        .ref_left_i(ref_left), .ref_above_i(ref_above), .gain_req_i(gain_req),
        .error_right_i(error_right), .error_bottom_i(error_bottom),
        .weight_left_i(w_left), .weight_above_i(w_above),
        .weight_right_i(w_right), .weight_below_i(w_below),
        .kp_i(kp), .ki_i(ki), .gain_ack_o(gain_ack), .gen_clk_o(gen_clk),
        .gen_div8_o(gen_div8), .error_left_o(error_left),
        .error_above_o(error_above), .dco_cc_o(dco_cc)
    );

    initial begin
        fpga_clk = 1'b0;
        forever #50 fpga_clk = ~fpga_clk;
    end

    function automatic int clamp(int v, int lo, int hi);
        return (v < lo) ? lo : (v > hi) ? hi : v;
    endfunction

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_range(int lo, int hi);
        rng_state = xorshift32(rng_state);
        return lo + int'(rng_state % 32'(hi - lo + 1));
    endfunction

    // Edge numbers as the detectors see them
    always @(posedge fpga_clk) begin
        cyc <= cyc + 1;
        div8_prev <= gen_div8;
        ref_prev <= ref_left;
        if (gen_div8 && !div8_prev) gen_seen_cyc <= cyc + 1;
        if (ref_left && !ref_prev) ref_seen_cyc <= cyc + 1;
    end

    // Reference model of the PI law stepped on each divided rising edge
    always @(posedge fpga_clk) begin
        int comb;
        int integ_n;
        int pi;
        if (rst) begin
            exp_integ <= 0;
            exp_cc <= 0;
            model_kp <= `NN_KP_DEFAULT;
            model_ki <= `NN_KI_DEFAULT;
            model_hold <= 1'b0;
        end else begin
            if (!model_hold && gain_req) begin
                model_kp <= int'(kp);
                model_ki <= int'(ki);
                model_hold <= 1'b1;
            end else if (model_hold && !gain_req) begin
                model_hold <= 1'b0;
            end
            if (gen_div8 && !div8_prev) begin
                comb = int'(w_above) * int'(error_above) + int'(w_left) * int'(error_left)
                     + int'(w_right) * int'(error_right) + int'(w_below) * int'(error_bottom);
                comb = clamp(comb >>> `NN_COMB_SHIFT, -16, 15);
                integ_n = clamp(exp_integ + model_ki * comb, -32768, 32767);
                pi = ((model_kp * comb) >>> `NN_KP_FRAC) + (integ_n >>> `NN_KI_FRAC);
                exp_integ <= integ_n;
                exp_cc <= clamp(pi, -16, 15);
            end
        end
    end

    task automatic report_mismatch(input int exp_v, input int act_v);
        $display("ERROR %s: expected %0d, actual %0d", test_name, exp_v, act_v);
        err_cnt++;
    endtask

    task automatic report_text(input string what);
        $display("%s: %s", test_name, what);
        err_cnt++;
    endtask

    a_reset: assert property (@(posedge fpga_clk) disable iff (!chk_reset)
        {gen_clk, gen_div8, gain_ack} == 3'b000 && error_left == 0 && error_above == 0
        && dco_cc == 0)
        else report_text("outputs not in their reset state");
    a_open: assert property (@(posedge fpga_clk) disable iff (!chk_open) dco_cc == 0)
        else report_mismatch(0, $sampled(dco_cc));
    a_frozen: assert property (@(posedge fpga_clk) disable iff (!chk_frozen) $stable(gen_div8))
        else report_text("divided clock toggled while enable_i was low");
    a_model: assert property (@(posedge fpga_clk) disable iff (!chk_model) dco_cc == exp_cc)
        else report_mismatch($sampled(exp_cc), $sampled(dco_cc));
    a_ack: assert property (@(posedge fpga_clk) disable iff (!chk_hs)
        1'b1 |=> gain_ack == $past(gain_req))
        else report_mismatch($past(gain_req), $sampled(gain_ack));
    a_pd_left: assert property (@(posedge fpga_clk) disable iff (!pd_chk)
        int'(error_left) == pd_exp)
        else report_mismatch($sampled(pd_exp), $sampled(error_left));
    a_pd_above: assert property (@(posedge fpga_clk) disable iff (!pd_chk)
        int'(error_above) == pd_exp)
        else report_mismatch($sampled(pd_exp), $sampled(error_above));
    a_sat: assert property (@(posedge fpga_clk) disable iff (!chk_sat) dco_cc == -16)
        else report_mismatch(-16, $sampled(dco_cc));

    task automatic tick();
        @(posedge fpga_clk);
        #10;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout in %s while waiting for %s", test_name, what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic wait_gen_edge();
        int start = gen_seen_cyc;
        int n = 0;
        while (gen_seen_cyc == start) begin
            tick();
            n++;
            if (n > 2000) abort_on_timeout("a divided clock edge");
        end
    endtask

    task automatic measure_period(output int p);
        int first;
        wait_gen_edge();
        first = gen_seen_cyc;
        wait_gen_edge();
        p = gen_seen_cyc - first;
    endtask

    task automatic load_gains(input int new_kp, input int new_ki);
        int n = 0;
        kp = kp_t'(new_kp);
        ki = ki_t'(new_ki);
        gain_req = 1'b1;
        while (!gain_ack) begin
            tick();
            n++;
            if (n > 20) abort_on_timeout("gain_ack_o high");
        end
        gain_req = 1'b0;
        kp = kp_t'(rand_range(0, 63));   // Must not be captured
        n = 0;
        while (gain_ack) begin
            tick();
            n++;
            if (n > 20) abort_on_timeout("gain_ack_o low");
        end
    endtask

    // Reference edge placed off cycles from the next divided edge
    task automatic phase_trial(input int off);
        int base = gen_seen_cyc;
        int target = gen_seen_cyc + 136 + off;
        int n = 0;
        while (cyc < target - 1) begin
            tick();
            n++;
            if (n > 400) abort_on_timeout("the reference slot");
        end
        ref_left = 1'b1;
        ref_above = 1'b1;
        repeat (3) tick();
        ref_left = 1'b0;
        ref_above = 1'b0;
        n = 0;
        while (ref_seen_cyc != target || gen_seen_cyc <= base) begin
            tick();
            n++;
            if (n > 400) abort_on_timeout("the edge pair");
        end
        pd_exp = clamp(ref_seen_cyc - gen_seen_cyc, -16, 15);
        pd_chk = 1'b1;
        tick();
        pd_chk = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_at_start = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_at_start) begin
            pass_cnt++;
            $display("%s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("%s: failed with %0d errors", test_name, err_cnt - err_at_start);
        end
    endtask

    initial begin
        int p;
        int n;
        rst = 1'b1;
        enable = 1'b1;
        {ref_left, ref_above, gain_req} = 3'b000;
        {error_right, error_bottom} = '0;
        {w_left, w_above, w_right, w_below} = '0;
        kp = '0;
        ki = '0;

        start_test("reset state");
        tick();
        chk_reset = 1'b1;
        repeat (7) tick();
        rst = 1'b0;
        repeat (3) tick();
        chk_reset = 1'b0;
        end_test();

        start_test("open loop");
        chk_open = 1'b1;
        chk_model = 1'b1;
        repeat (4) begin
            measure_period(p);
            assert (clamp(p * `NN_BIAS - 8 * (1 << `NN_ACC_W), -`NN_BIAS, `NN_BIAS)
                    == p * `NN_BIAS - 8 * (1 << `NN_ACC_W))
                else report_mismatch(8 * (1 << `NN_ACC_W) / `NN_BIAS, p);
        end
        enable = 1'b0;
        tick();
        chk_frozen = 1'b1;
        repeat (300) tick();
        chk_frozen = 1'b0;
        enable = 1'b1;
        chk_open = 1'b0;
        end_test();

        start_test("phase detection");
        wait_gen_edge();
        repeat (58) tick();
        ref_left = 1'b1;   // Closes the pair left open since reset
        ref_above = 1'b1;
        repeat (3) tick();
        ref_left = 1'b0;
        ref_above = 1'b0;
        phase_trial(-28);
        phase_trial(27);
        repeat (10) phase_trial(rand_range(-30, 30));
        end_test();

        start_test("combine and filter");
        w_right = weight_t'(rand_range(1, 15));
        w_below = weight_t'(rand_range(1, 15));
        error_right = phase_err_t'(rand_range(-16, 15));
        error_bottom = phase_err_t'(rand_range(-16, 15));
        repeat (12) wait_gen_edge();
        end_test();

        start_test("gain handshake");
        chk_hs = 1'b1;
        load_gains(rand_range(0, 63), rand_range(0, 255));
        repeat (8) wait_gen_edge();
        chk_hs = 1'b0;
        end_test();

        start_test("saturation");
        load_gains(63, 255);
        w_right = 4'd15;
        w_below = '0;
        error_right = -16;
        n = 0;
        while (dco_cc != -16) begin
            tick();
            n++;
            if (n > 3000) abort_on_timeout("dco_cc_o at its limit");
        end
        chk_sat = 1'b1;
        wait_gen_edge();
        repeat (3) begin
            measure_period(p);
            // Bias minus code gives the word
            n = clamp(`NN_BIAS - int'(dco_cc), 0, 63);
            assert (p < 136 && clamp(p * n - 2048, -n, n) == p * n - 2048)
                else report_mismatch(2048 / n, p);
        end
        chk_sat = 1'b0;
        end_test();

        chk_model = 1'b0;
        $display("summary: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* network_node.f */
+incdir+common
common/network_node_pkg.sv
phase_detector/phase_detector.sv
verilog/error_combiner.sv
loop_filter/loop_filter.sv
verilog/dco.sv
verilog/network_node.sv
bench/network_node_tb.sv

/* Bender.yml */
package:
  name: network_node

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/network_node_pkg.sv
      - phase_detector/phase_detector.sv
      - verilog/error_combiner.sv
      - loop_filter/loop_filter.sv
      - verilog/dco.sv
      - verilog/network_node.sv

  - target: test
    include_dirs:
      - common
    files:
      - bench/network_node_tb.sv
